// File: design/pipe_cfg.svh
`ifndef PIPE_CFG_SVH
`define PIPE_CFG_SVH

// issue width; the CSR merge logic is written for two lanes
`define PIPE_LANES 2

`define PIPE_DATA_W 32

`define PIPE_REGS 32

`define PIPE_CSRS 4

`endif

// File: design/pipe_pkg.sv
`include "pipe_cfg.svh"

package pipe_pkg;

    typedef logic [`PIPE_DATA_W-1:0]         data_t;
    typedef logic [$clog2(`PIPE_REGS)-1:0]   reg_addr_t;
    typedef logic [$clog2(`PIPE_CSRS)-1:0]   csr_addr_t;

    typedef enum logic [5:0] {
        OP_NOP   = 6'h00,
        OP_ADD   = 6'h01,
        OP_SUB   = 6'h02,
        OP_AND   = 6'h03,
        OP_OR    = 6'h04,
        OP_XOR   = 6'h05,
        OP_ADDI  = 6'h06,
        OP_LUI   = 6'h07,
        OP_CSRRD = 6'h08,
        OP_CSRWR = 6'h09
    } opcode_t;

    // instruction word: opcode [31:26], rd [25:21], rs1 [20:16], imm [15:0]
    // rs2 shares the top of the immediate field at [15:11]
    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        logic [15:0] imm;
    } instr_t;

    // imm is already extended or shifted by decode
    typedef struct packed {
        logic      valid;
        logic      illegal;
        opcode_t   op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        data_t     imm;
        csr_addr_t csr_addr;
    } dec_ex_t;

    typedef struct packed {
        logic      valid;
        logic      illegal;
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        data_t     reg_write_data;
        logic      csr_write_en;
        csr_addr_t csr_write_addr;
        data_t     csr_write_data;
    } ex_wb_t;

    typedef struct packed {
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        data_t     reg_write_data;
    } reg_pf_t;

    typedef struct packed {
        logic      csr_write_en;
        csr_addr_t csr_write_addr;
        data_t     csr_write_data;
    } csr_pf_t;

endpackage

// File: design/issue_decode.sv
`timescale 1ns/1ps
`include "pipe_cfg.svh"

module issue_decode
    import pipe_pkg::*;
(
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  logic [`PIPE_LANES-1:0][31:0]       instr_i,
    input  logic [`PIPE_LANES-1:0]             instr_valid_i,
    input  logic                               pause_i,
    input  logic                               flush_i,
    output dec_ex_t [`PIPE_LANES-1:0]          dec_o
);

    dec_ex_t [`PIPE_LANES-1:0] dec_d;

    function automatic dec_ex_t decode_lane(input instr_t w, input logic v);
        dec_ex_t d;
        data_t   imm_sext;
        data_t   imm_high;
        d        = '0;
        imm_sext = {{(`PIPE_DATA_W-16){w.imm[15]}}, w.imm};
        imm_high = {w.imm, {(`PIPE_DATA_W-16){1'b0}}};
        // a lane without valid stays an all-zero bubble
        if (v) begin
            d.valid    = 1'b1;
            d.rd       = w.rd;
            d.rs1      = w.rs1;
            d.rs2      = w.imm[15:11];
            d.csr_addr = w.imm[$bits(csr_addr_t)-1:0];
            case (w.opcode)
                OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                OP_ADDI, OP_LUI, OP_CSRRD, OP_CSRWR: begin
                    d.op = opcode_t'(w.opcode);
                end
                default: begin
                    // unknown opcode flows on as a flagged no-op
                    d.op      = OP_NOP;
                    d.illegal = 1'b1;
                end
            endcase
            d.imm = (d.op == OP_LUI) ? imm_high : imm_sext;
        end
        return d;
    endfunction

    always_comb begin
        for (int l = 0; l < `PIPE_LANES; l++) begin
            dec_d[l] = decode_lane(instr_t'(instr_i[l]), instr_valid_i[l]);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_o <= '0;
        end else if (flush_i) begin
            dec_o <= '0;
        end else if (!pause_i) begin
            dec_o <= dec_d;
        end
    end

endmodule

// File: design/lane_execute.sv
`timescale 1ns/1ps
`include "pipe_cfg.svh"

module lane_execute
    import pipe_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 arst_n_i,
    input  logic                                 pause_i,
    input  logic                                 flush_i,
    input  dec_ex_t   [`PIPE_LANES-1:0]          dec_i,
    output reg_addr_t [2*`PIPE_LANES-1:0]        rf_raddr_o,
    input  data_t     [2*`PIPE_LANES-1:0]        rf_rdata_i,
    output csr_addr_t [`PIPE_LANES-1:0]          csr_raddr_o,
    input  data_t     [`PIPE_LANES-1:0]          csr_rdata_i,
    input  reg_pf_t   [`PIPE_LANES-1:0]          wb_reg_pf_i,
    input  csr_pf_t                              wb_csr_pf_i,
    output ex_wb_t    [`PIPE_LANES-1:0]          ex_o
);

    data_t  [`PIPE_LANES-1:0] op_a;
    data_t  [`PIPE_LANES-1:0] op_b;
    data_t  [`PIPE_LANES-1:0] op_c;
    ex_wb_t [`PIPE_LANES-1:0] ex_d;

    // later assignments win, so the younger stage and lane 1 go last
    function automatic data_t fwd_reg(input reg_addr_t addr, input data_t stored,
                                      input ex_wb_t [`PIPE_LANES-1:0] ex_q,
                                      input reg_pf_t [`PIPE_LANES-1:0] wb_pf);
        data_t v;
        v = stored;
        for (int l = 0; l < `PIPE_LANES; l++) begin
            if (wb_pf[l].reg_write_en && wb_pf[l].reg_write_addr == addr) begin
                v = wb_pf[l].reg_write_data;
            end
        end
        for (int l = 0; l < `PIPE_LANES; l++) begin
            if (ex_q[l].reg_write_en && ex_q[l].reg_write_addr == addr) begin
                v = ex_q[l].reg_write_data;
            end
        end
        return v;
    endfunction

    // lane 0 owns the CSR port, so its execute result is checked last
    function automatic data_t fwd_csr(input csr_addr_t addr, input data_t stored,
                                      input ex_wb_t [`PIPE_LANES-1:0] ex_q,
                                      input csr_pf_t wb_pf);
        data_t v;
        v = stored;
        if (wb_pf.csr_write_en && wb_pf.csr_write_addr == addr) begin
            v = wb_pf.csr_write_data;
        end
        for (int l = `PIPE_LANES - 1; l >= 0; l--) begin
            if (ex_q[l].csr_write_en && ex_q[l].csr_write_addr == addr) begin
                v = ex_q[l].csr_write_data;
            end
        end
        return v;
    endfunction

    function automatic ex_wb_t exec_lane(input dec_ex_t d, input data_t a,
                                         input data_t b, input data_t c);
        ex_wb_t e;
        data_t  res;
        logic   wr_rd;
        e     = '0;
        res   = '0;
        wr_rd = 1'b1;
        case (d.op)
            OP_ADD:   res = a + b;
            OP_SUB:   res = a - b;
            OP_AND:   res = a & b;
            OP_OR:    res = a | b;
            OP_XOR:   res = a ^ b;
            OP_ADDI:  res = a + d.imm;
            OP_LUI:   res = d.imm;
            OP_CSRRD: res = c;
            OP_CSRWR: begin
                // old value to rd, rs1 into the CSR
                res              = c;
                e.csr_write_en   = d.valid;
                e.csr_write_addr = d.csr_addr;
                e.csr_write_data = a;
            end
            default:  wr_rd = 1'b0;
        endcase
        e.valid   = d.valid;
        e.illegal = d.illegal;
        // x0 is never a destination
        if (d.valid && wr_rd && d.rd != '0) begin
            e.reg_write_en   = 1'b1;
            e.reg_write_addr = d.rd;
            e.reg_write_data = res;
        end
        return e;
    endfunction

    always_comb begin
        for (int l = 0; l < `PIPE_LANES; l++) begin
            rf_raddr_o[2*l]     = dec_i[l].rs1;
            rf_raddr_o[2*l + 1] = dec_i[l].rs2;
            csr_raddr_o[l]      = dec_i[l].csr_addr;
        end
    end

    always_comb begin
        for (int l = 0; l < `PIPE_LANES; l++) begin
            op_a[l] = fwd_reg(dec_i[l].rs1, rf_rdata_i[2*l], ex_o, wb_reg_pf_i);
            op_b[l] = fwd_reg(dec_i[l].rs2, rf_rdata_i[2*l + 1], ex_o, wb_reg_pf_i);
            op_c[l] = fwd_csr(dec_i[l].csr_addr, csr_rdata_i[l], ex_o, wb_csr_pf_i);
            ex_d[l] = exec_lane(dec_i[l], op_a[l], op_b[l], op_c[l]);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_o <= '0;
        end else if (flush_i) begin
            ex_o <= '0;
        end else if (!pause_i) begin
            ex_o <= ex_d;
        end
    end

endmodule

// File: design/result_wb.sv
`timescale 1ns/1ps
`include "pipe_cfg.svh"

module result_wb
    import pipe_pkg::*;
(
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          pause_i,
    input  logic                          flush_i,
    input  ex_wb_t  [`PIPE_LANES-1:0]     ex_i,
    output ex_wb_t  [`PIPE_LANES-1:0]     wb_o,
    output reg_pf_t [`PIPE_LANES-1:0]     wb_reg_pf_o,
    output csr_pf_t                       wb_csr_pf_o
);

    // flush also stands in for a memory-side hold
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_o <= '0;
        end else if (flush_i) begin
            wb_o <= '0;
        end else if (!pause_i) begin
            wb_o <= ex_i;
        end
    end

    // one register push-forward per lane
    always_comb begin
        for (int l = 0; l < `PIPE_LANES; l++) begin
            wb_reg_pf_o[l].reg_write_en   = wb_o[l].reg_write_en;
            wb_reg_pf_o[l].reg_write_addr = wb_o[l].reg_write_addr;
            wb_reg_pf_o[l].reg_write_data = wb_o[l].reg_write_data;
        end
    end

    // single CSR port where lane 0 goes first
    assign wb_csr_pf_o.csr_write_en   = wb_o[0].csr_write_en || wb_o[1].csr_write_en;
    assign wb_csr_pf_o.csr_write_addr = wb_o[0].csr_write_en ? wb_o[0].csr_write_addr
                                                             : wb_o[1].csr_write_addr;
    assign wb_csr_pf_o.csr_write_data = wb_o[0].csr_write_en ? wb_o[0].csr_write_data
                                                             : wb_o[1].csr_write_data;

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps
`include "pipe_cfg.svh"

module reg_file
    import pipe_pkg::*;
(
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  reg_pf_t   [`PIPE_LANES-1:0]        wr_i,
    input  reg_addr_t [2*`PIPE_LANES-1:0]      raddr_i,
    output data_t     [2*`PIPE_LANES-1:0]      rdata_o
);

    data_t regs [`PIPE_REGS];

    // lane 1 is written last and wins on a shared address
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs <= '{default: '0};
        end else begin
            for (int l = 0; l < `PIPE_LANES; l++) begin
                if (wr_i[l].reg_write_en && wr_i[l].reg_write_addr != '0) begin
                    regs[wr_i[l].reg_write_addr] <= wr_i[l].reg_write_data;
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2*`PIPE_LANES; p++) begin
            if (raddr_i[p] == '0) begin
                rdata_o[p] = '0;
            end else begin
                rdata_o[p] = regs[raddr_i[p]];
            end
        end
    end

endmodule

// File: design/csr_file.sv
`timescale 1ns/1ps
`include "pipe_cfg.svh"

module csr_file
    import pipe_pkg::*;
(
    input  logic                             clk,
    input  logic                             arst_n_i,
    input  csr_pf_t                          wr_i,
    input  csr_addr_t [`PIPE_LANES-1:0]      raddr_i,
    output data_t     [`PIPE_LANES-1:0]      rdata_o
);

    data_t csrs [`PIPE_CSRS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            csrs <= '{default: '0};
        end else if (wr_i.csr_write_en) begin
            csrs[wr_i.csr_write_addr] <= wr_i.csr_write_data;
        end
    end

    // one read port per lane
    always_comb begin
        for (int p = 0; p < `PIPE_LANES; p++) begin
            rdata_o[p] = csrs[raddr_i[p]];
        end
    end

endmodule

// File: design/pipe_top.sv
`timescale 1ns/1ps
`include "pipe_cfg.svh"

module pipe_top
    import pipe_pkg::*;
(
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic [`PIPE_LANES-1:0][31:0]   instr_i,
    input  logic [`PIPE_LANES-1:0]         instr_valid_i,
    input  logic                           pause_i,
    input  logic                           flush_i,
    output ex_wb_t [`PIPE_LANES-1:0]       commit_o
);

    dec_ex_t   [`PIPE_LANES-1:0]     dec_q;
    ex_wb_t    [`PIPE_LANES-1:0]     ex_q;
    reg_pf_t   [`PIPE_LANES-1:0]     wb_reg_pf;
    csr_pf_t                         wb_csr_pf;
    reg_addr_t [2*`PIPE_LANES-1:0]   rf_raddr;
    data_t     [2*`PIPE_LANES-1:0]   rf_rdata;
    csr_addr_t [`PIPE_LANES-1:0]     csr_raddr;
    data_t     [`PIPE_LANES-1:0]     csr_rdata;

    issue_decode u_decode (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .pause_i       (pause_i),
        .flush_i       (flush_i),
        .dec_o         (dec_q)
    );

    lane_execute u_execute (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .pause_i     (pause_i),
        .flush_i     (flush_i),
        .dec_i       (dec_q),
        .rf_raddr_o  (rf_raddr),
        .rf_rdata_i  (rf_rdata),
        .csr_raddr_o (csr_raddr),
        .csr_rdata_i (csr_rdata),
        .wb_reg_pf_i (wb_reg_pf),
        .wb_csr_pf_i (wb_csr_pf),
        .ex_o        (ex_q)
    );

    // the writeback register is the commit view
    result_wb u_wb (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .pause_i     (pause_i),
        .flush_i     (flush_i),
        .ex_i        (ex_q),
        .wb_o        (commit_o),
        .wb_reg_pf_o (wb_reg_pf),
        .wb_csr_pf_o (wb_csr_pf)
    );

    reg_file u_rf (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wr_i     (wb_reg_pf),
        .raddr_i  (rf_raddr),
        .rdata_o  (rf_rdata)
    );

    csr_file u_csr (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wr_i     (wb_csr_pf),
        .raddr_i  (csr_raddr),
        .rdata_o  (csr_rdata)
    );

endmodule

// File: dv/clk_rst_gen.sv
`timescale 1ns/1ps

module clk_rst_gen (
    output logic clk,
    output logic arst_n_o
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // four cycles of reset released between edges
    initial begin
        arst_n_o = 1'b0;
        repeat (4) @(posedge clk);
        #10;
        arst_n_o = 1'b1;
    end

endmodule

// File: dv/tb_pipe.sv
`timescale 1ns/1ps
`include "pipe_cfg.svh"

module tb_pipe
    import pipe_pkg::*;
();

    typedef struct packed {
        logic [`PIPE_LANES-1:0][31:0] w;
        logic [`PIPE_LANES-1:0]       v;
        int                           cyc;
        int                           pcnt;
    } issued_t;

    localparam logic [31:0] nop_w = 32'h0000_0000;

    logic                          clk;
    logic                          arst_n;
    logic [`PIPE_LANES-1:0][31:0]  instr;
    logic [`PIPE_LANES-1:0]        instr_valid;
    logic                          pause;
    logic                          flush;
    ex_wb_t [`PIPE_LANES-1:0]      commit;
    ex_wb_t [`PIPE_LANES-1:0]      held;

    logic [31:0] m_regs [`PIPE_REGS];
    logic [31:0] m_csrs [`PIPE_CSRS];
    issued_t     iss_q [$];
    logic [31:0] lfsr;
    logic        last_pause;
    logic        last_flush;
    int          cyc;
    int          paused_cnt;
    int          checks;
    int          errs;
    int          fails;

    clk_rst_gen u_clk (
        .clk      (clk),
        .arst_n_o (arst_n)
    );

    pipe_top dut (
        .clk           (clk),
        .arst_n_i      (arst_n),
        .instr_i       (instr),
        .instr_valid_i (instr_valid),
        .pause_i       (pause),
        .flush_i       (flush),
        .commit_o      (commit)
    );

    // galois form with taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
            r    = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = rand_bits(3);
        return r[4:0];
    endfunction

    function automatic opcode_t rand_alu_op();
        logic [31:0] r;
        r = rand_bits(3) % 32'd5 + 32'd1;
        return opcode_t'(r[5:0]);
    endfunction

    function automatic logic [31:0] alu_word(input opcode_t op, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
        return {op, rd, rs1, rs2, 11'h000};
    endfunction

    function automatic logic [31:0] imm_word(input opcode_t op, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [15:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    // expected commit of one lane from the model state before its bundle
    function automatic ex_wb_t predict(input logic [31:0] w, input logic v);
        ex_wb_t      e;
        logic [5:0]  op;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        wr;
        e   = '0;
        op  = w[31:26];
        rd  = w[25:21];
        imm = w[15:0];
        a   = m_regs[w[20:16]];
        b   = m_regs[w[15:11]];
        res = '0;
        wr  = 1'b1;
        if (!v) begin
            return e;
        end
        e.valid = 1'b1;
        case (op)
            OP_ADD:   res = a + b;
            OP_SUB:   res = a - b;
            OP_AND:   res = a & b;
            OP_OR:    res = a | b;
            OP_XOR:   res = a ^ b;
            OP_ADDI:  res = a + {{16{imm[15]}}, imm};
            OP_LUI:   res = {imm, 16'h0000};
            OP_CSRRD: res = m_csrs[imm[1:0]];
            OP_CSRWR: begin
                res              = m_csrs[imm[1:0]];
                e.csr_write_en   = 1'b1;
                e.csr_write_addr = imm[1:0];
                e.csr_write_data = a;
            end
            OP_NOP:   wr = 1'b0;
            default: begin
                wr        = 1'b0;
                e.illegal = 1'b1;
            end
        endcase
        if (wr && rd != 5'd0) begin
            e.reg_write_en   = 1'b1;
            e.reg_write_addr = rd;
            e.reg_write_data = res;
        end
        return e;
    endfunction

    // lane 1 register write lands last and lane 0 owns the CSR port
    task automatic apply_commit(input ex_wb_t e0, input ex_wb_t e1);
        if (e0.reg_write_en) m_regs[e0.reg_write_addr] = e0.reg_write_data;
        if (e1.reg_write_en) m_regs[e1.reg_write_addr] = e1.reg_write_data;
        if (e0.csr_write_en) begin
            m_csrs[e0.csr_write_addr] = e0.csr_write_data;
        end else if (e1.csr_write_en) begin
            m_csrs[e1.csr_write_addr] = e1.csr_write_data;
        end
    endtask

    task automatic check_commit(input int lane, input ex_wb_t got, input ex_wb_t exp);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("error %0t: lane %0d commit %h, expected %h", $time, lane, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        checks++;
        if (got != exp) begin
            errs++;
            $display("error %0t: commit latency %0d cycles, expected %0d", $time, got, exp);
        end
    endtask

    // commit_o is sampled on the falling edge before new inputs go out
    task automatic watch_commit();
        issued_t e;
        ex_wb_t  exp0;
        ex_wb_t  exp1;
        if (last_pause && !last_flush) begin
            check_commit(0, commit[0], held[0]);
            check_commit(1, commit[1], held[1]);
        end else if (commit[0].valid || commit[1].valid) begin
            if (iss_q.size() == 0) begin
                fails++;
                $display("a bundle committed at %0t with nothing in flight", $time);
            end else begin
                e    = iss_q.pop_front();
                exp0 = predict(e.w[0], e.v[0]);
                exp1 = predict(e.w[1], e.v[1]);
                check_latency(cyc - e.cyc, 3 + paused_cnt - e.pcnt);
                check_commit(0, commit[0], exp0);
                check_commit(1, commit[1], exp1);
                apply_commit(exp0, exp1);
            end
        end
        held = commit;
    endtask

    task automatic step(input logic [31:0] w0, input logic [31:0] w1,
                        input logic [1:0] v, input logic p, input logic f);
        issued_t e;
        @(negedge clk);
        cyc++;
        watch_commit();
        instr       = {w1, w0};
        instr_valid = v;
        pause       = p;
        flush       = f;
        if (p && !f) paused_cnt++;
        // flush drops everything in flight and the bundle on the inputs
        if (f) begin
            iss_q.delete();
        end else if (!p && v != 2'b00) begin
            e.w    = {w1, w0};
            e.v    = v;
            e.cyc  = cyc;
            e.pcnt = paused_cnt;
            iss_q.push_back(e);
        end
        last_pause = p;
        last_flush = f;
    endtask

    task automatic issue(input logic [31:0] w0, input logic [31:0] w1);
        step(w0, w1, 2'b11, 1'b0, 1'b0);
    endtask

    task automatic drain(input int limit);
        int n;
        n = 0;
        while (iss_q.size() != 0 && n < limit) begin
            step(nop_w, nop_w, 2'b00, 1'b0, 1'b0);
            n++;
        end
        if (iss_q.size() != 0) begin
            fails++;
            $display("timeout: %0d bundles never committed within %0d cycles",
                     iss_q.size(), limit);
            iss_q.delete();
        end
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (arst_n !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (arst_n !== 1'b1) begin
            fails++;
            $display("reset was still asserted after 20 cycles");
        end
    endtask

    task automatic reset_and_upper_imm();
        check_commit(0, commit[0], '0);
        check_commit(1, commit[1], '0);
        held = commit;
        issue(imm_word(OP_LUI, 5'd1, 5'd0, 16'h1234), imm_word(OP_ADDI, 5'd2, 5'd0, 16'hfffb));
        issue(imm_word(OP_ADDI, 5'd3, 5'd1, 16'h0042), imm_word(OP_LUI, 5'd4, 5'd0, 16'hbeef));
        drain(10);
    endtask

    task automatic random_alu_chain();
        logic [31:0] r0;
        logic [31:0] r1;
        for (int i = 0; i < 4; i++) begin
            r0 = rand_bits(16);
            r1 = rand_bits(16);
            issue(imm_word(OP_LUI, 5'(2*i + 1), 5'd0, r0[15:0]),
                  imm_word(OP_ADDI, 5'(2*i + 2), 5'd0, r1[15:0]));
        end
        for (int i = 0; i < 24; i++) begin
            issue(alu_word(rand_alu_op(), rand_reg(), rand_reg(), rand_reg()),
                  alu_word(rand_alu_op(), rand_reg(), rand_reg(), rand_reg()));
        end
        drain(10);
    endtask

    task automatic same_bundle_rules();
        issue(imm_word(OP_ADDI, 5'd5, 5'd0, 16'd100), nop_w);
        // lane 1 still sees r5 from before the bundle
        issue(imm_word(OP_ADDI, 5'd5, 5'd5, 16'd1), alu_word(OP_ADD, 5'd6, 5'd5, 5'd0));
        issue(imm_word(OP_ADDI, 5'd7, 5'd0, 16'd11), imm_word(OP_ADDI, 5'd7, 5'd0, 16'd22));
        issue(alu_word(OP_ADD, 5'd8, 5'd7, 5'd0), imm_word(OP_ADDI, 5'd0, 5'd0, 16'd99));
        drain(10);
        issue(alu_word(OP_OR, 5'd9, 5'd7, 5'd0), alu_word(OP_ADD, 5'd10, 5'd0, 5'd6));
        drain(10);
    endtask

    task automatic csr_access();
        issue(imm_word(OP_ADDI, 5'd1, 5'd0, 16'h0055), imm_word(OP_ADDI, 5'd2, 5'd0, 16'h00aa));
        issue(imm_word(OP_CSRWR, 5'd3, 5'd1, 16'd1), imm_word(OP_CSRRD, 5'd4, 5'd0, 16'd1));
        issue(imm_word(OP_CSRRD, 5'd5, 5'd0, 16'd1), imm_word(OP_CSRWR, 5'd6, 5'd2, 16'd1));
        // both lanes write csr 2
        issue(imm_word(OP_CSRWR, 5'd0, 5'd1, 16'd2), imm_word(OP_CSRWR, 5'd0, 5'd2, 16'd2));
        issue(imm_word(OP_CSRRD, 5'd7, 5'd0, 16'd2), imm_word(OP_CSRRD, 5'd8, 5'd0, 16'd1));
        drain(10);
        issue(imm_word(OP_CSRRD, 5'd9, 5'd0, 16'd2), imm_word(OP_CSRRD, 5'd10, 5'd0, 16'd1));
        drain(10);
    endtask

    task automatic pause_and_flush();
        issue(imm_word(OP_ADDI, 5'd11, 5'd0, 16'd7), nop_w);
        issue(imm_word(OP_ADDI, 5'd12, 5'd11, 16'd3), imm_word(OP_LUI, 5'd13, 5'd0, 16'h00c3));
        step(nop_w, nop_w, 2'b00, 1'b0, 1'b0);
        repeat (3) step(nop_w, nop_w, 2'b00, 1'b1, 1'b0);
        drain(12);
        issue(imm_word(OP_ADDI, 5'd14, 5'd0, 16'h0077), nop_w);
        issue(imm_word(OP_ADDI, 5'd11, 5'd0, 16'h0099), nop_w);
        step(imm_word(OP_ADDI, 5'd12, 5'd0, 16'h0011), nop_w, 2'b11, 1'b0, 1'b1);
        repeat (4) step(nop_w, nop_w, 2'b00, 1'b0, 1'b0);
        issue(alu_word(OP_ADD, 5'd15, 5'd11, 5'd14), alu_word(OP_OR, 5'd16, 5'd12, 5'd0));
        drain(10);
    endtask

    task automatic unknown_opcode();
        issue({6'h3f, 5'd3, 5'd1, 16'h0001}, {6'h0a, 5'd4, 5'd0, 16'h0000});
        issue(alu_word(OP_ADD, 5'd17, 5'd3, 5'd4), nop_w);
        drain(10);
    endtask

    initial begin
        instr       = '0;
        instr_valid = '0;
        pause       = 1'b0;
        flush       = 1'b0;
        held        = '0;
        last_pause  = 1'b0;
        last_flush  = 1'b0;
        lfsr        = 32'hd5a1_2d8a;
        cyc         = 0;
        paused_cnt  = 0;
        checks      = 0;
        errs        = 0;
        fails       = 0;
        for (int i = 0; i < `PIPE_REGS; i++) m_regs[i] = '0;
        for (int i = 0; i < `PIPE_CSRS; i++) m_csrs[i] = '0;
        wait_reset();
        reset_and_upper_imm();
        random_alu_chain();
        same_bundle_rules();
        csr_access();
        pause_and_flush();
        unknown_opcode();
        $display("%0d checks, %0d value errors, %0d other failures", checks, errs, fails);
        if (errs == 0 && fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+design
design/pipe_pkg.sv
design/issue_decode.sv
design/lane_execute.sv
design/result_wb.sv
design/reg_file.sv
design/csr_file.sv
design/pipe_top.sv
dv/clk_rst_gen.sv
dv/tb_pipe.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_pipe -f project.f -o tb_pipe \
    && ./obj_dir/tb_pipe > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1
exit 0
